/* Makefile */
# Verilator build and run for the raster bars testbench

SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_raster_bars
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src/display_timing.sv */
// display timing generator
// scans the full frame and decodes sync pulses and data enable

module display_timing import raster_pkg::*; #(
    parameter int h_res  = 640,  // active pixels per line
    parameter int h_fp   = 16,   // horizontal front porch
    parameter int h_sync = 96,   // horizontal sync width
    parameter int h_bp   = 48,   // horizontal back porch
    parameter int v_res  = 480,  // active lines per frame
    parameter int v_fp   = 10,   // vertical front porch
    parameter int v_sync = 2,    // vertical sync width
    parameter int v_bp   = 33    // vertical back porch
) (
    input  logic             clk_pix,  // pixel clock
    input  logic             arst_n,   // async active-low reset
    output logic [cordw-1:0] sx,       // horizontal position
    output logic [cordw-1:0] sy,       // vertical position
    output sync_t            sync      // sync and de for current position
);

    // line and frame totals including blanking
    localparam int h_total = h_res + h_fp + h_sync + h_bp;
    localparam int v_total = v_res + v_fp + v_sync + v_bp;

    // sync windows run from start up to but not including end
    localparam int hs_start = h_res + h_fp;
    localparam int hs_end   = h_res + h_fp + h_sync;
    localparam int vs_start = v_res + v_fp;
    localparam int vs_end   = v_res + v_fp + v_sync;

    logic line_end;   // last pixel of a line
    logic frame_end;  // last line of a frame
    logic hs_win;     // inside horizontal sync window
    logic vs_win;     // inside vertical sync window

    always_comb begin
        line_end  = (sx == h_total - 1);  // wrap point for sx
        frame_end = (sy == v_total - 1);  // wrap point for sy
    end

    // horizontal counter steps once per pixel clock
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;  // back to left edge
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // vertical counter steps when a line wraps
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;  // back to top of screen
            end else begin
                sy <= sy + 1'b1;
            end
        end
    end

    // sync decode in the same cycle as the counters
    always_comb begin
        hs_win     = (sx >= hs_start) && (sx < hs_end);
        vs_win     = (sy >= vs_start) && (sy < vs_end);
        sync.hsync = ~hs_win;                       // negative polarity as in 480p
        sync.vsync = ~vs_win;                       // negative polarity
        sync.de    = (sx < h_res) && (sy < v_res);  // active area only
    end

    // both counters stay inside the frame
    a_counters_in_frame : assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        (sx < h_total) && (sy < v_total)
    );

endmodule

/* src/raster_bar_gen.sv */
// raster bar colour sequencer
// steps the colour once per line in bands that rise and then fall
// and reloads the start state on the last line of each frame

module raster_bar_gen import raster_pkg::*; #(
    parameter int     h_res      = 640,      // active pixels per line
    parameter int     v_res      = 480,      // active lines per frame
    parameter int     v_fp       = 10,       // vertical front porch
    parameter int     v_sync     = 2,        // vertical sync width
    parameter int     v_bp       = 33,       // vertical back porch
    parameter rgb12_t start_colr = 12'h126,  // colour at top of frame
    parameter int     colr_num   = 10,       // colour steps per band
    parameter int     line_num   = 2         // lines per colour
) (
    input  logic             clk_pix,  // pixel clock
    input  logic             arst_n,   // async active-low reset
    input  logic [cordw-1:0] sx,       // horizontal position
    input  logic [cordw-1:0] sy,       // vertical position
    output rgb12_t           bar_colr  // colour for the current line
);

    localparam int v_total = v_res + v_fp + v_sync + v_bp;  // lines incl blanking
    localparam int colr_cw = $clog2(colr_num) + 1;          // colour counter width
    localparam int line_cw = $clog2(line_num) + 1;          // line counter width

    bar_dir_t           bar_dir;   // brightness direction
    logic [colr_cw-1:0] cnt_colr;  // colours done in this band
    logic [line_cw-1:0] cnt_line;  // lines done in this colour
    logic               line_upd;  // first blanking pixel of a line
    logic               last_line; // last line of the frame
    logic               colr_done; // all lines of this colour shown
    logic               band_done; // all colours of this band shown
    rgb12_t             colr_next; // colour one step on

    always_comb begin
        line_upd  = (sx == h_res);
        last_line = (sy == v_total - 1);
        colr_done = (cnt_line == line_cw'(line_num - 1));
        band_done = (cnt_colr == colr_cw'(colr_num - 1));
        if (bar_dir == dir_up) begin
            colr_next = rgb12_t'(bar_colr + colr_step);  // brighter
        end else begin
            colr_next = rgb12_t'(bar_colr - colr_step);  // darker
        end
    end

    // band sequencer acts once per line at start of blanking
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            bar_colr <= start_colr;
            bar_dir  <= dir_up;
            cnt_colr <= '0;
            cnt_line <= '0;
        end else if (line_upd) begin
            if (last_line) begin
                // reload so the next frame starts like the first
                bar_colr <= start_colr;
                bar_dir  <= dir_up;
                cnt_colr <= '0;
                cnt_line <= '0;
            end else if (colr_done) begin
                cnt_line <= '0;
                if (band_done) begin
                    // reverse and hold colour for one more group
                    bar_dir  <= (bar_dir == dir_up) ? dir_down : dir_up;
                    cnt_colr <= '0;
                end else begin
                    bar_colr <= colr_next;           // next shade
                    cnt_colr <= cnt_colr + 1'b1;
                end
            end else begin
                cnt_line <= cnt_line + 1'b1;  // same colour on the next line
            end
        end
    end

    // step count stays bounded so no channel wraps
    a_step_bound : assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        cnt_colr <= colr_cw'(colr_num - 1)
    );

endmodule

/* src/raster_bars_top.sv */
// raster bars top level
// sets screen and band shape, connects timing, bar generator and output

module raster_bars_top import raster_pkg::*; #(
    parameter int     h_res      = 640,      // active pixels per line
    parameter int     h_fp       = 16,       // horizontal front porch
    parameter int     h_sync     = 96,       // horizontal sync width
    parameter int     h_bp       = 48,       // horizontal back porch
    parameter int     v_res      = 480,      // active lines per frame
    parameter int     v_fp       = 10,       // vertical front porch
    parameter int     v_sync     = 2,        // vertical sync width
    parameter int     v_bp       = 33,       // vertical back porch
    parameter rgb12_t start_colr = 12'h126,  // blue bars, 12'h640 gives gold
    parameter int     colr_num   = 10,       // colour steps per band
    parameter int     line_num   = 2         // lines per colour
) (
    input  logic   clk_pix,    // pixel clock
    input  logic   arst_n,     // async reset, active low
    output logic   vga_hsync,  // VGA horizontal sync
    output logic   vga_vsync,  // VGA vertical sync
    output rgb12_t vga_colr    // VGA colour, 4 bits per channel
);

    logic [cordw-1:0] sx;        // horizontal position
    logic [cordw-1:0] sy;        // vertical position
    sync_t            sync;      // sync and de, same cycle as sx/sy
    rgb12_t           bar_colr;  // line colour before blanking

    display_timing #(
        .h_res  (h_res),
        .h_fp   (h_fp),
        .h_sync (h_sync),
        .h_bp   (h_bp),
        .v_res  (v_res),
        .v_fp   (v_fp),
        .v_sync (v_sync),
        .v_bp   (v_bp)
    ) timing0 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .sync    (sync)
    );

    raster_bar_gen #(
        .h_res      (h_res),
        .v_res      (v_res),
        .v_fp       (v_fp),
        .v_sync     (v_sync),
        .v_bp       (v_bp),
        .start_colr (start_colr),
        .colr_num   (colr_num),
        .line_num   (line_num)
    ) bars0 (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .sx       (sx),
        .sy       (sy),
        .bar_colr (bar_colr)
    );

    // one clock from pixel position to pins
    vga_output out0 (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .sync      (sync),
        .bar_colr  (bar_colr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_colr  (vga_colr)
    );

endmodule

/* src/raster_pkg.sv */
// raster bars shared types
// colour and sync words, bar direction and the colour step

package raster_pkg;

    // screen coordinate width, wide enough for 640x480 plus blanking
    localparam int cordw = 10;

    // one colour, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;  // red
        logic [3:0] g;  // green
        logic [3:0] b;  // blue
    } rgb12_t;

    // sync and data enable for one pixel
    typedef struct packed {
        logic hsync;  // horizontal sync, active low
        logic vsync;  // vertical sync, active low
        logic de;     // data enable, high in active area
    } sync_t;

    // which way the bar brightness moves
    typedef enum logic {
        dir_up   = 1'b0,  // getting brighter
        dir_down = 1'b1   // getting darker
    } bar_dir_t;

    // adds one to every channel in a single add
    localparam logic [11:0] colr_step = 12'h111;

endpackage

/* src/vga_output.sv */
// VGA output stage
// blanks the colour outside the active area and registers the pins

module vga_output import raster_pkg::*; (
    input  logic   clk_pix,    // pixel clock
    input  logic   arst_n,     // async reset, active low
    input  sync_t  sync,       // sync and de from timing
    input  rgb12_t bar_colr,   // colour for the current line
    output logic   vga_hsync,  // registered hsync
    output logic   vga_vsync,  // registered vsync
    output rgb12_t vga_colr    // registered colour
);

    rgb12_t disp_colr;  // colour after blanking

    // black everywhere except the active area
    always_comb begin
        if (sync.de) begin
            disp_colr = bar_colr;
        end else begin
            disp_colr = '0;
        end
    end

    // one register stage, so pins change cleanly on the clock edge
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;  // inactive level
            vga_vsync <= 1'b1;  // inactive level
            vga_colr  <= '0;
        end else begin
            vga_hsync <= sync.hsync;
            vga_vsync <= sync.vsync;
            vga_colr  <= disp_colr;
        end
    end

    // colour pins dark one cycle after de was low
    a_blank_out : assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        !sync.de |=> (vga_colr == '0)
    );

endmodule

/* verif/tb_raster_bars.sv */
// raster bars testbench
// runs a small screen for two frames, captures the pins per pixel and
// checks reset levels, sync pulses, blanking and the bar colour rule

module tb_raster_bars import raster_pkg::*; ();

    // small screen so whole frames run quickly
    localparam int     h_res      = 16;
    localparam int     h_fp       = 2;
    localparam int     h_sync     = 3;
    localparam int     h_bp       = 3;
    localparam int     v_res      = 24;
    localparam int     v_fp       = 1;
    localparam int     v_sync     = 2;
    localparam int     v_bp       = 1;
    localparam rgb12_t start_colr = 12'h126;
    localparam int     colr_num   = 4;
    localparam int     line_num   = 2;

    localparam int h_total        = h_res + h_fp + h_sync + h_bp;  // 24 clocks per line
    localparam int v_total        = v_res + v_fp + v_sync + v_bp;  // 28 lines per frame
    localparam int frame_cycles   = h_total * v_total;
    localparam int num_frames     = 2;                             // frames captured
    localparam int rst_samples    = 3;                             // two in reset, one after
    localparam int timeout_cycles = 3 * frame_cycles + 50;

    typedef enum int {k_reset, k_sync, k_colr, k_blank} check_kind_t;

    logic   clk_pix;
    logic   arst_n;
    logic   vga_hsync;
    logic   vga_vsync;
    rgb12_t vga_colr;

    // pins captured per pixel, indexed by the tb's own position count
    logic   cap_hs   [num_frames][v_total][h_total];
    logic   cap_vs   [num_frames][v_total][h_total];
    rgb12_t cap_colr [num_frames][v_total][h_total];
    logic   rst_hs   [rst_samples];
    logic   rst_vs   [rst_samples];
    rgb12_t rst_colr [rst_samples];

    // check table, one entry per row
    string       row_name  [$];
    int          row_frame [$];
    int          row_first [$];
    int          row_last  [$];
    check_kind_t row_kind  [$];

    int rows_passed = 0;
    int rows_failed = 0;
    int cycle_cnt   = 0;

    raster_bars_top #(
        .h_res      (h_res),
        .h_fp       (h_fp),
        .h_sync     (h_sync),
        .h_bp       (h_bp),
        .v_res      (v_res),
        .v_fp       (v_fp),
        .v_sync     (v_sync),
        .v_bp       (v_bp),
        .start_colr (start_colr),
        .colr_num   (colr_num),
        .line_num   (line_num)
    ) dut0 (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_colr  (vga_colr)
    );

    always #4 clk_pix = ~clk_pix;  // period 8

    // run limit, three frames plus some slack
    always @(posedge clk_pix) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run still going after %0d clock cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    // colour rule for line y, up then hold then down in groups of line_num
    function automatic rgb12_t line_colr(input int y);
        int grp;
        int pos;
        int level;
        grp = y / line_num;
        pos = grp % (2 * colr_num);
        if (pos < colr_num) begin
            level = pos;                     // rising half
        end else begin
            level = 2 * colr_num - 1 - pos;  // falling half, top level held once
        end
        return rgb12_t'(12'(start_colr) + 12'(level) * colr_step);
    endfunction

    function automatic bar_dir_t line_dir(input int y);
        int pos;
        pos = (y / line_num) % (2 * colr_num);
        return (pos < colr_num) ? dir_up : dir_down;
    endfunction

    function automatic logic hs_expect(input int x);
        return !((x >= h_res + h_fp) && (x < h_res + h_fp + h_sync));  // active low
    endfunction

    function automatic logic vs_expect(input int y);
        return !((y >= v_res + v_fp) && (y < v_res + v_fp + v_sync));
    endfunction

    task automatic add_row(input string name, input int frame, input int first,
                           input int last, input check_kind_t kind);
        row_name.push_back(name);
        row_frame.push_back(frame);
        row_first.push_back(first);
        row_last.push_back(last);
        row_kind.push_back(kind);
    endtask

    task automatic build_table();
        add_row("reset_idle", 0, 0, 0, k_reset);
        add_row("sync_f0", 0, 0, v_total - 1, k_sync);
        // band edges below hold for colr_num 4 and line_num 2
        add_row("colr_up_f0", 0, 0, 7, k_colr);
        add_row("colr_top_hold_f0", 0, 8, 9, k_colr);
        add_row("colr_down_f0", 0, 10, 15, k_colr);
        add_row("colr_low_hold_f0", 0, 16, 17, k_colr);
        add_row("colr_rise_f0", 0, 18, v_res - 1, k_colr);
        add_row("blank_f0", 0, 0, v_total - 1, k_blank);
        add_row("sync_f1", 1, 0, v_total - 1, k_sync);
        add_row("colr_f1", 1, 0, v_res - 1, k_colr);  // reload at frame end
        add_row("blank_f1", 1, 0, v_total - 1, k_blank);
    endtask

    // sample pins at each falling edge, position is one clock behind the DUT
    task automatic capture_frames();
        int px;
        int py;
        px = 0;
        py = 0;
        for (int f = 0; f < num_frames; f++) begin
            for (int n = 0; n < frame_cycles; n++) begin
                @(negedge clk_pix);
                cap_hs[f][py][px]   = vga_hsync;
                cap_vs[f][py][px]   = vga_vsync;
                cap_colr[f][py][px] = vga_colr;
                if (px == h_total - 1) begin
                    px = 0;
                    py = (py == v_total - 1) ? 0 : py + 1;  // frame wrap
                end else begin
                    px = px + 1;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        int          checked;
        int          wrong;
        int          f;
        logic        visible;
        logic        in_scope;
        logic [13:0] exp_v;
        logic [13:0] act_v;
        checked = 0;
        wrong   = 0;
        f       = row_frame[r];
        if (row_kind[r] == k_reset) begin
            for (int i = 0; i < rst_samples; i++) begin
                exp_v = {1'b1, 1'b1, 12'h000};  // syncs inactive, black
                act_v = {rst_hs[i], rst_vs[i], rst_colr[i]};
                checked++;
                if (act_v !== exp_v) begin
                    wrong++;
                    $display("FAIL %s sample %0d expected %h actual %h",
                             row_name[r], i, exp_v, act_v);
                end
            end
        end else begin
            for (int y = row_first[r]; y <= row_last[r]; y++) begin
                for (int x = 0; x < h_total; x++) begin
                    visible = (x < h_res) && (y < v_res);
                    case (row_kind[r])
                        k_sync: begin
                            in_scope = 1'b1;
                            exp_v    = {12'h000, hs_expect(x), vs_expect(y)};
                            act_v    = {12'h000, cap_hs[f][y][x], cap_vs[f][y][x]};
                        end
                        k_colr: begin
                            in_scope = visible;
                            exp_v    = {2'b00, line_colr(y)};
                            act_v    = {2'b00, cap_colr[f][y][x]};
                        end
                        default: begin
                            in_scope = !visible;  // blanking only
                            exp_v    = '0;
                            act_v    = {2'b00, cap_colr[f][y][x]};
                        end
                    endcase
                    if (in_scope) begin
                        checked++;
                        if (act_v !== exp_v) begin
                            wrong++;
                            if (wrong <= 4) begin
                                $display("FAIL %s line %0d pixel %0d (%s) expected %h actual %h",
                                         row_name[r], y, x, line_dir(y).name(), exp_v, act_v);
                            end
                        end
                    end
                end
            end
        end
        if (checked == 0) begin
            rows_failed++;
            $display("row %s checked no samples, its range is empty", row_name[r]);
        end else if (wrong != 0) begin
            rows_failed++;
            $display("row %s failed, %0d of %0d samples wrong", row_name[r], wrong, checked);
        end else begin
            rows_passed++;
            $display("row %s passed, %0d samples", row_name[r], checked);
        end
    endtask

    initial begin
        clk_pix = 1'b0;
        arst_n  = 1'b0;
        build_table();
        // reset seen on three rising edges, released by the last one
        for (int i = 0; i < rst_samples; i++) begin
            @(posedge clk_pix);
            if (i == rst_samples - 1) begin
                arst_n <= 1'b1;
            end
            @(negedge clk_pix);
            rst_hs[i]   = vga_hsync;
            rst_vs[i]   = vga_vsync;
            rst_colr[i] = vga_colr;
        end
        @(posedge clk_pix);  // first counting edge, pins now show pixel (0,0)
        capture_frames();
        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end
        $display("rows run %0d, passed %0d, failed %0d",
                 row_name.size(), rows_passed, rows_failed);
        if (rows_failed == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/raster_pkg.sv
src/display_timing.sv
src/raster_bar_gen.sv
src/vga_output.sv
src/raster_bars_top.sv
verif/tb_raster_bars.sv
